/* design/dcache_geom_pkg.sv */
// data cache geometry: address fields, frame layout and width types, imported by all RTL
package dcache_geom_pkg;

    // cache shape
    parameter int NUM_SETS      = 8;
    parameter int WORDS_PER_BLK = 2;

    // a data word as seen by the processor and memory
    typedef logic [31:0] word_t;

    // address field widths
    typedef logic [25:0] tag_t;
    typedef logic [2:0]  set_idx_t;
    typedef logic [0:0]  blk_off_t;

    // way select within a set
    typedef logic way_t;

    // byte address split into cache fields
    typedef struct packed {
        tag_t       tag;
        set_idx_t   idx;
        blk_off_t   blkoff;
        logic [1:0] bytoff;
    } dcache_addr_t;

    // one cache frame: status bits, tag and the block's words
    typedef struct packed {
        logic                         valid;
        logic                         dirty;
        tag_t                         tag;
        word_t [WORDS_PER_BLK-1:0]    data;
    } frame_t;

endpackage

/* design/dcache_bus_pkg.sv */
// request and response bundles for the processor and memory sides of the data cache
package dcache_bus_pkg;

    import dcache_geom_pkg::*;

    // processor request, held until hit
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } dp_req_t;

    // processor response, rdata valid only with hit
    typedef struct packed {
        logic  hit;
        word_t rdata;
    } dp_rsp_t;

    // memory request, held steady while busy
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // memory response, word completes on the edge where busy is low
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } mem_rsp_t;

endpackage

/* design/dcache_array.sv */
// frame and recently-used storage of the data cache, with tag lookup, victim select and update ports
`timescale 1ns/1ps

module dcache_array
    import dcache_geom_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,

    // lookup from the processor address
    input  set_idx_t lookup_set,
    input  tag_t     lookup_tag,
    output logic     hit,
    output way_t     hit_way,
    output way_t     victim_way,
    output frame_t   victim_frame,
    output frame_t   hit_frame,

    // full frame write
    input  logic     upd_en,
    input  set_idx_t upd_set,
    input  way_t     upd_way,
    input  frame_t   upd_frame,

    // recently-used update
    input  logic     touch_en,
    input  set_idx_t touch_set,
    input  way_t     touch_way,

    // flush walk
    input  set_idx_t scan_set,
    input  way_t     scan_way,
    output frame_t   scan_frame
);

    frame_t [NUM_SETS-1:0][1:0] frames;

    // holds the way used last in each set
    logic [NUM_SETS-1:0] recent;

    logic [1:0] way_match;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            frames <= '0;
            recent <= '0;
        end else begin
            if (upd_en) begin
                frames[upd_set][upd_way] <= upd_frame;
            end
            if (touch_en) begin
                recent[touch_set] <= touch_way;
            end
        end
    end

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_match[w] = frames[lookup_set][w].valid &&
                           (frames[lookup_set][w].tag == lookup_tag);
        end
    end

    assign hit       = |way_match;
    assign hit_way   = way_t'(way_match[1]);
    assign hit_frame = frames[lookup_set][hit_way];

    // replace the way that was not used last
    assign victim_way   = way_t'(~recent[lookup_set]);
    assign victim_frame = frames[lookup_set][victim_way];

    assign scan_frame = frames[scan_set][scan_way];

    // the controller must never fill a block that is already resident
    for (genvar s = 0; s < NUM_SETS; s++) begin : g_dup_check
        a_no_dup_tag: assert property (
            @(posedge CLK) disable iff (!nRST)
            !(frames[s][0].valid && frames[s][1].valid &&
              (frames[s][0].tag == frames[s][1].tag))
        ) else $error("set %0d holds the same tag in both ways", s);
    end

endmodule

/* design/dcache_ctrl.sv */
// data cache controller: serves hits, runs write-back and allocate on misses, flushes on halt
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,

    // processor side
    input  dp_req_t  dp_req,
    output dp_rsp_t  dp_rsp,
    input  logic     halt,
    output logic     flushed,

    // memory side
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,

    // array lookup
    output set_idx_t lookup_set,
    output tag_t     lookup_tag,
    input  logic     hit,
    input  way_t     hit_way,
    input  way_t     victim_way,
    input  frame_t   victim_frame,
    input  frame_t   hit_frame,

    // array frame write
    output logic     upd_en,
    output set_idx_t upd_set,
    output way_t     upd_way,
    output frame_t   upd_frame,

    // array recently-used update
    output logic     touch_en,
    output set_idx_t touch_set,
    output way_t     touch_way,

    // array flush walk
    output set_idx_t scan_set,
    output way_t     scan_way,
    input  frame_t   scan_frame
);

    typedef enum logic [3:0] {
        IDLE,
        WB0,
        WB1,
        ALLOC0,
        ALLOC1,
        FLUSH_SCAN,
        FLUSH_WB0,
        FLUSH_WB1,
        FLUSHED
    } state_t;

    state_t       state, next_state;
    logic [3:0]   slot, next_slot;
    dcache_addr_t req_addr;
    logic         req_valid;
    logic         last_slot;

    // word-aligned byte address of one word in a block
    function automatic word_t blk_addr(tag_t tag, set_idx_t idx, blk_off_t off);
        dcache_addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = off;
        a.bytoff = 2'b00;
        return word_t'(a);
    endfunction

    assign req_addr  = dcache_addr_t'(dp_req.addr);
    assign req_valid = dp_req.ren || dp_req.wen;

    assign lookup_set = req_addr.idx;
    assign lookup_tag = req_addr.tag;
    assign touch_set  = req_addr.idx;
    assign touch_way  = hit_way;

    // slot counter walks way 0 of every set, then way 1
    assign scan_set  = slot[2:0];
    assign scan_way  = way_t'(slot[3]);
    assign last_slot = (slot == 4'hF);

    assign flushed = (state == FLUSHED);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            slot  <= '0;
        end else begin
            state <= next_state;
            slot  <= next_slot;
        end
    end

    always_comb begin
        next_state   = state;
        next_slot    = slot;
        dp_rsp.hit   = 1'b0;
        dp_rsp.rdata = hit_frame.data[req_addr.blkoff];
        mem_req      = '0;
        upd_en       = 1'b0;
        upd_set      = req_addr.idx;
        upd_way      = victim_way;
        upd_frame    = victim_frame;
        touch_en     = 1'b0;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FLUSH_SCAN;
                    next_slot  = '0;
                end else if (req_valid) begin
                    if (hit) begin
                        dp_rsp.hit = 1'b1;
                        touch_en   = 1'b1;
                        if (dp_req.wen) begin
                            upd_en    = 1'b1;
                            upd_way   = hit_way;
                            upd_frame = hit_frame;
                            upd_frame.dirty = 1'b1;
                            upd_frame.data[req_addr.blkoff] = dp_req.wdata;
                        end
                    end else if (victim_frame.valid && victim_frame.dirty) begin
                        next_state = WB0;
                    end else begin
                        next_state = ALLOC0;
                    end
                end
            end
            WB0, WB1: begin
                mem_req.wen = 1'b1;
                mem_req.addr = blk_addr(victim_frame.tag, req_addr.idx, blk_off_t'(state == WB1));
                mem_req.wdata = victim_frame.data[state == WB1];
                if (!mem_rsp.busy) begin
                    next_state = (state == WB0) ? WB1 : ALLOC0;
                end
            end
            ALLOC0: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(req_addr.tag, req_addr.idx, 1'b0);
                if (!mem_rsp.busy) begin
                    // half-filled frame stays invalid
                    upd_en    = 1'b1;
                    upd_frame.valid   = 1'b0;
                    upd_frame.dirty   = 1'b0;
                    upd_frame.data[0] = mem_rsp.rdata;
                    next_state = ALLOC1;
                end
            end
            ALLOC1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = blk_addr(req_addr.tag, req_addr.idx, 1'b1);
                if (!mem_rsp.busy) begin
                    upd_en    = 1'b1;
                    upd_frame.valid   = 1'b1;
                    upd_frame.dirty   = 1'b0;
                    upd_frame.tag     = req_addr.tag;
                    upd_frame.data[1] = mem_rsp.rdata;
                    next_state = IDLE;
                end
            end
            FLUSH_SCAN: begin
                if (scan_frame.valid && scan_frame.dirty) begin
                    next_state = FLUSH_WB0;
                end else if (last_slot) begin
                    next_state = FLUSHED;
                end else begin
                    next_slot = slot + 4'd1;
                end
            end
            FLUSH_WB0, FLUSH_WB1: begin
                mem_req.wen = 1'b1;
                mem_req.addr = blk_addr(scan_frame.tag, scan_set, blk_off_t'(state == FLUSH_WB1));
                mem_req.wdata = scan_frame.data[state == FLUSH_WB1];
                if (!mem_rsp.busy) begin
                    if (state == FLUSH_WB0) begin
                        next_state = FLUSH_WB1;
                    end else begin
                        // block is now clean in memory
                        upd_en    = 1'b1;
                        upd_set   = scan_set;
                        upd_way   = scan_way;
                        upd_frame = scan_frame;
                        upd_frame.dirty = 1'b0;
                        next_state = last_slot ? FLUSHED : FLUSH_SCAN;
                        next_slot  = last_slot ? slot : slot + 4'd1;
                    end
                end
            end
            FLUSHED: begin
                next_state = FLUSHED;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // memory handshake rules
    a_req_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.busy |=> $stable(mem_req)
    ) else $error("memory request changed while busy");

    a_ren_wen_excl: assert property (
        @(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen)
    ) else $error("memory ren and wen both high");

endmodule

/* design/dcache_top.sv */
// data cache top level, joining the controller and the frame array to the processor and memory ports
`timescale 1ns/1ps

module dcache_top
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,

    input  dp_req_t  dp_req,
    output dp_rsp_t  dp_rsp,
    input  logic     halt,
    output logic     flushed,

    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // lookup path
    set_idx_t lookup_set;
    tag_t     lookup_tag;
    logic     hit;
    way_t     hit_way;
    way_t     victim_way;
    frame_t   victim_frame;
    frame_t   hit_frame;

    // write paths
    logic     upd_en;
    set_idx_t upd_set;
    way_t     upd_way;
    frame_t   upd_frame;
    logic     touch_en;
    set_idx_t touch_set;
    way_t     touch_way;

    // flush walk
    set_idx_t scan_set;
    way_t     scan_way;
    frame_t   scan_frame;

    dcache_ctrl i_dcache_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .dp_req       (dp_req),
        .dp_rsp       (dp_rsp),
        .halt         (halt),
        .flushed      (flushed),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .lookup_set   (lookup_set),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_frame (victim_frame),
        .hit_frame    (hit_frame),
        .upd_en       (upd_en),
        .upd_set      (upd_set),
        .upd_way      (upd_way),
        .upd_frame    (upd_frame),
        .touch_en     (touch_en),
        .touch_set    (touch_set),
        .touch_way    (touch_way),
        .scan_set     (scan_set),
        .scan_way     (scan_way),
        .scan_frame   (scan_frame)
    );

    dcache_array i_dcache_array (
        .CLK          (CLK),
        .nRST         (nRST),
        .lookup_set   (lookup_set),
        .lookup_tag   (lookup_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_frame (victim_frame),
        .hit_frame    (hit_frame),
        .upd_en       (upd_en),
        .upd_set      (upd_set),
        .upd_way      (upd_way),
        .upd_frame    (upd_frame),
        .touch_en     (touch_en),
        .touch_set    (touch_set),
        .touch_way    (touch_way),
        .scan_set     (scan_set),
        .scan_way     (scan_way),
        .scan_frame   (scan_frame)
    );

endmodule

/* testbench/mem_model.sv */
// word memory behind the data cache in the testbench, with a fixed busy wait before each word
`timescale 1ns/1ps

module mem_model
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
#(
    parameter int BUSY_CYCLES = 2,
    parameter int DEPTH       = 256
)(
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    word_t mem [DEPTH];

    // cycles spent busy on the current word
    int wait_cnt;

    logic                     active;
    logic [$clog2(DEPTH)-1:0] widx;

    assign active = mem_req.ren || mem_req.wen;
    assign widx   = mem_req.addr[$clog2(DEPTH)+1:2];

    assign mem_rsp.busy  = active && (wait_cnt < BUSY_CYCLES);
    assign mem_rsp.rdata = mem[widx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 0;
            // every word starts as its own byte address with the upper half scrambled
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= word_t'(i * 4) ^ 32'hA5A5_0000;
            end
        end else if (active) begin
            if (mem_rsp.busy) begin
                wait_cnt <= wait_cnt + 1;
            end else begin
                wait_cnt <= 0;
                if (mem_req.wen) begin
                    mem[widx] <= mem_req.wdata;
                end
            end
        end else begin
            wait_cnt <= 0;
        end
    end

endmodule

/* testbench/tb_dcache.sv */
// top-level data cache testbench that runs a load and store table and checks the halt flush
`timescale 1ns/1ps

module tb_dcache
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int MEM_WORDS    = 256;
    localparam int BUSY_CYCLES  = 2;
    // four dirty blocks are left resident when halt comes
    localparam int FLUSH_WRITES = 8;

    typedef enum logic {OP_LOAD, OP_STORE} op_t;

    // one table row with the request and the memory words it should cost
    typedef struct packed {
        op_t   op;
        word_t addr;
        word_t wdata;
        int    exp_rd;
        int    exp_wr;
    } entry_t;

    logic     CLK;
    logic     nRST;
    dp_req_t  dp_req;
    dp_rsp_t  dp_rsp;
    logic     halt;
    logic     flushed;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    entry_t stim_q [$];
    word_t  shadow [MEM_WORDS];

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int cycles = 0;
    int cycle_limit = 0;
    int rd_done = 0;
    int wr_done = 0;
    int req_cycles = 0;
    int entry_rd_start = 0;

    dcache_top i_dcache_top (
        .CLK     (CLK),
        .nRST    (nRST),
        .dp_req  (dp_req),
        .dp_rsp  (dp_rsp),
        .halt    (halt),
        .flushed (flushed),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    mem_model #(
        .BUSY_CYCLES (BUSY_CYCLES),
        .DEPTH       (MEM_WORDS)
    ) i_mem (
        .CLK     (CLK),
        .nRST    (nRST),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    // counts memory words, each completing at the next rising edge with busy low
    always @(negedge CLK) begin
        if (nRST) begin
            if (mem_req.ren || mem_req.wen) begin
                req_cycles++;
            end
            if ((mem_req.ren || mem_req.wen) && !mem_rsp.busy) begin
                assert (mem_req.addr < 32'h400) else begin
                    $display("memory access outside the modeled range at %h", mem_req.addr);
                    errors++;
                end
                if (mem_req.ren) begin
                    rd_done++;
                    assert (mem_rsp.rdata == shadow[mem_req.addr[9:2]]) else begin
                        $display("Fail mem_rsp.rdata at %h: expected %h, got %h", mem_req.addr,
                                 shadow[mem_req.addr[9:2]], mem_rsp.rdata);
                        errors++;
                    end
                end else begin
                    wr_done++;
                    assert (mem_req.wdata == shadow[mem_req.addr[9:2]]) else begin
                        $display("Fail mem_req.wdata at %h: expected %h, got %h", mem_req.addr,
                                 shadow[mem_req.addr[9:2]], mem_req.wdata);
                        errors++;
                    end
                    // write-back must finish before the fill starts
                    assert (rd_done == entry_rd_start) else begin
                        $display("a write-back word came after a fill read of the same miss");
                        errors++;
                    end
                end
            end
        end
    end

    task automatic add_entry(input op_t op, input word_t addr, input word_t wdata,
                             input int exp_rd, input int exp_wr);
        entry_t e;
        e.op     = op;
        e.addr   = addr;
        e.wdata  = wdata;
        e.exp_rd = exp_rd;
        e.exp_wr = exp_wr;
        stim_q.push_back(e);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic run_entry(input int n, input entry_t e);
        int rd_base;
        int wr_base;
        int err_before;
        int idx;
        err_before = errors;
        idx = int'(e.addr[9:2]);
        @(negedge CLK);
        rd_base = rd_done;
        wr_base = wr_done;
        entry_rd_start = rd_done;
        dp_req.ren   = (e.op == OP_LOAD);
        dp_req.wen   = (e.op == OP_STORE);
        dp_req.addr  = e.addr;
        dp_req.wdata = e.wdata;
        @(negedge CLK);
        while (!dp_rsp.hit) begin
            @(negedge CLK);
        end
        // request stays held through the rising edge after hit
        if (e.op == OP_LOAD) begin
            assert (dp_rsp.rdata == shadow[idx]) else begin
                $display("Fail dp_rsp.rdata at %h: expected %h, got %h", e.addr,
                         shadow[idx], dp_rsp.rdata);
                errors++;
            end
        end else begin
            shadow[idx] = e.wdata;
        end
        assert (rd_done - rd_base == e.exp_rd) else begin
            $display("Fail mem reads: expected %h, got %h", e.exp_rd, rd_done - rd_base);
            errors++;
        end
        assert (wr_done - wr_base == e.exp_wr) else begin
            $display("Fail mem writes: expected %h, got %h", e.exp_wr, wr_done - wr_base);
            errors++;
        end
        report_test($sformatf("entry %0d %s %h", n, e.op.name(), e.addr), err_before);
    endtask

    initial begin
        int err_before;
        int wr_base;
        int rd_base;

        // op, address, write data, memory reads, memory writes
        add_entry(OP_LOAD,  32'h0000_0000, 32'h0000_0000, 2, 0);
        add_entry(OP_LOAD,  32'h0000_0004, 32'h0000_0000, 0, 0);
        add_entry(OP_STORE, 32'h0000_0004, 32'h1111_2222, 0, 0);
        add_entry(OP_LOAD,  32'h0000_0004, 32'h0000_0000, 0, 0);
        // set 1 victim choice with tags A, B, C
        add_entry(OP_LOAD,  32'h0000_0008, 32'h0000_0000, 2, 0);
        add_entry(OP_LOAD,  32'h0000_0048, 32'h0000_0000, 2, 0);
        add_entry(OP_LOAD,  32'h0000_000C, 32'h0000_0000, 0, 0);
        add_entry(OP_LOAD,  32'h0000_0088, 32'h0000_0000, 2, 0);
        add_entry(OP_LOAD,  32'h0000_0008, 32'h0000_0000, 0, 0);
        add_entry(OP_LOAD,  32'h0000_004C, 32'h0000_0000, 2, 0);
        // set 2 dirty eviction
        add_entry(OP_STORE, 32'h0000_0010, 32'hCAFE_0010, 2, 0);
        add_entry(OP_STORE, 32'h0000_0014, 32'hCAFE_0014, 0, 0);
        add_entry(OP_LOAD,  32'h0000_0050, 32'h0000_0000, 2, 0);
        add_entry(OP_LOAD,  32'h0000_0090, 32'h0000_0000, 2, 2);
        add_entry(OP_LOAD,  32'h0000_0014, 32'h0000_0000, 2, 0);
        // dirty lines left for the flush
        add_entry(OP_STORE, 32'h0000_00A0, 32'h0BAD_00A0, 2, 0);
        add_entry(OP_STORE, 32'h0000_01E4, 32'h0BAD_01E4, 2, 0);
        add_entry(OP_STORE, 32'h0000_03F8, 32'h0BAD_03F8, 2, 0);

        cycle_limit = RESET_CYCLES + stim_q.size() * 20 + 400;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = word_t'(i * 4) ^ 32'hA5A5_0000;
        end

        nRST   = 1'b0;
        halt   = 1'b0;
        dp_req = '0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;

        err_before = errors;
        repeat (2) @(negedge CLK);
        assert (!dp_rsp.hit && !flushed && !mem_req.ren && !mem_req.wen) else begin
            $display("outputs not idle after reset");
            errors++;
        end
        assert (req_cycles == 0) else begin
            $display("memory request seen before the first table entry");
            errors++;
        end
        report_test("reset", err_before);

        foreach (stim_q[i]) begin
            run_entry(i, stim_q[i]);
        end

        err_before = errors;
        @(negedge CLK);
        dp_req  = '0;
        wr_base = wr_done;
        rd_base = rd_done;
        entry_rd_start = rd_done;
        halt    = 1'b1;
        while (!flushed) begin
            @(negedge CLK);
        end
        repeat (4) @(negedge CLK);
        assert (flushed) else begin
            $display("flushed dropped after it was raised");
            errors++;
        end
        assert (wr_done - wr_base == FLUSH_WRITES) else begin
            $display("Fail flush writes: expected %h, got %h", FLUSH_WRITES, wr_done - wr_base);
            errors++;
        end
        assert (rd_done == rd_base) else begin
            $display("Fail flush reads: expected %h, got %h", 0, rd_done - rd_base);
            errors++;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (i_mem.mem[i] == shadow[i]) else begin
                $display("Fail mem word %h: expected %h, got %h", i * 4, shadow[i], i_mem.mem[i]);
                errors++;
            end
        end
        report_test("halt flush", err_before);

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* dcache.f */
design/dcache_geom_pkg.sv
design/dcache_bus_pkg.sv
design/dcache_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build the data cache testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_dcache -f dcache.f &&
{ sim_out="$(./obj_dir/Vtb_dcache)"; printf '%s\n' "$sim_out"; } &&
printf '%s\n' "$sim_out" | grep -qxF 'All tests passed!' &&
echo "dcache simulation: PASS" ||
{ echo "dcache simulation: FAIL"; exit 1; }
